/* rtl/fp_alu_pkg.sv */
/*
 * Shared constants and types of the floating-point ALU
 * Half values sit in the low 16 bits of a 32-bit word
 * Results are truncated, no rounding mode exists
 */
package fp_alu_pkg;

    // ========================================
    // Widths that carry a meaning
    // ========================================
    typedef logic [31:0]        fp_word_t;
    typedef logic [7:0]         exp_t;
    typedef logic signed [9:0]  exp_wide_t;
    typedef logic [23:0]        sig_t;
    typedef logic [22:0]        frac_t;

    // Format constants
    localparam exp_t     SINGLE_EXP_MAX = 8'd255;
    localparam exp_t     HALF_EXP_MAX   = 8'd31;
    localparam exp_t     SINGLE_BIAS    = 8'd127;
    localparam exp_t     HALF_BIAS      = 8'd15;
    localparam fp_word_t QNAN_SINGLE    = 32'h7FC0_0000;
    localparam fp_word_t QNAN_HALF      = 32'h0000_7E00;
    localparam int       HALF_FRAC_PAD  = 13;

    // ========================================
    // Enums and structs
    // ========================================
    typedef enum logic {FMT_HALF = 1'b0, FMT_SINGLE = 1'b1} fp_fmt_e;

    // Code 3 is reserved and runs as multiply
    typedef enum logic [1:0] {OP_ADD, OP_SUB, OP_MUL, OP_RSVD} alu_op_e;

    typedef enum logic {ST_IDLE, ST_COMPUTE} alu_state_e;

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic underflow;
    } alu_flags_t;

    typedef struct packed {
        logic sign;
        exp_t exp;
        sig_t sig;
        logic is_nan;
        logic is_inf;
        logic is_zero;
        logic is_denorm;
    } fp_operand_t;

    typedef enum logic [1:0] {RAW_NUM, RAW_NAN, RAW_INF, RAW_ZERO} raw_kind_e;

    // Exponent may lie outside the format range here
    typedef struct packed {
        raw_kind_e kind;
        logic      sign;
        exp_wide_t exp;
        frac_t     frac;
    } fp_raw_t;

endpackage

/* rtl/fp_unpack.sv */
/*
 * Splits one operand word into sign, exponent and significand
 * Half fractions are left-aligned to single width
 * Denormals get no hidden bit and keep exponent zero
 */
module fp_unpack (
    input  fp_alu_pkg::fp_word_t    word,
    input  fp_alu_pkg::fp_fmt_e     fmt,
    output fp_alu_pkg::fp_operand_t opnd
);
    import fp_alu_pkg::*;

    logic  sign;
    exp_t  exp_f;
    frac_t frac;
    exp_t  exp_all_ones;

    always_comb begin
        if (fmt == FMT_SINGLE) begin
            sign         = word[31];
            exp_f        = word[30:23];
            frac         = word[22:0];
            exp_all_ones = SINGLE_EXP_MAX;
        end else begin
            sign         = word[15];
            exp_f        = {3'b000, word[14:10]};
            frac         = {word[9:0], {HALF_FRAC_PAD{1'b0}}};
            exp_all_ones = HALF_EXP_MAX;
        end
    end

    // Classification against the format's all-ones exponent
    always_comb begin
        opnd.sign      = sign;
        opnd.exp       = exp_f;
        opnd.sig       = {(exp_f != '0), frac};
        opnd.is_nan    = (exp_f == exp_all_ones) && (frac != '0);
        opnd.is_inf    = (exp_f == exp_all_ones) && (frac == '0);
        opnd.is_zero   = (exp_f == '0) && (frac == '0);
        opnd.is_denorm = (exp_f == '0) && (frac != '0);
    end

endmodule

/* rtl/fp_add_sub.sv */
/*
 * Floating-point add and subtract on unpacked operands
 * Three guard bits below the significand, result truncated
 * Output exponent is unbounded, range checks happen in the packer
 */
module fp_add_sub (
    input  fp_alu_pkg::fp_operand_t a,
    input  fp_alu_pkg::fp_operand_t b,
    input  logic                    subtract,
    output fp_alu_pkg::fp_raw_t     raw
);
    import fp_alu_pkg::*;

    logic        sign_b_eff;
    logic        a_ge_b;
    logic        eff_sub;
    logic        res_sign;
    exp_t        big_exp;
    exp_t        exp_diff;
    sig_t        big_sig;
    sig_t        small_sig;
    logic [27:0] big_mag;
    logic [27:0] small_mag;
    logic [27:0] sum;
    logic [27:0] norm;
    logic [4:0]  lzc;

    assign sign_b_eff = b.sign ^ subtract;
    assign eff_sub    = (a.sign != sign_b_eff);

    // ========================================
    // Alignment to the larger magnitude
    // ========================================
    assign a_ge_b    = {a.exp, a.sig} >= {b.exp, b.sig};
    assign res_sign  = a_ge_b ? a.sign : sign_b_eff;
    assign big_exp   = a_ge_b ? a.exp : b.exp;
    assign big_sig   = a_ge_b ? a.sig : b.sig;
    assign small_sig = a_ge_b ? b.sig : a.sig;
    assign exp_diff  = big_exp - (a_ge_b ? b.exp : a.exp);

    // Bit 27 catches the carry, hidden bit sits at 26
    assign big_mag   = {1'b0, big_sig, 3'b000};
    assign small_mag = {1'b0, small_sig, 3'b000} >> exp_diff;
    assign sum       = eff_sub ? (big_mag - small_mag) : (big_mag + small_mag);

    // Leading zeros of sum[26:0], highest set bit wins
    always_comb begin
        lzc = 5'd0;
        for (int i = 0; i <= 26; i++) begin
            if (sum[i]) begin
                lzc = 5'(26 - i);
            end
        end
    end

    assign norm = sum << lzc;

    // ========================================
    // Special values first, then the number
    // ========================================
    always_comb begin
        raw = '0;
        if (a.is_nan || b.is_nan || (a.is_inf && b.is_inf && eff_sub)) begin
            raw.kind = RAW_NAN;
        end else if (a.is_inf || b.is_inf) begin
            raw.kind = RAW_INF;
            raw.sign = a.is_inf ? a.sign : sign_b_eff;
        end else if (a.is_zero && b.is_zero) begin
            raw.kind = RAW_ZERO;
            raw.sign = a.sign & sign_b_eff;
        end else if (a.is_zero) begin
            raw.kind = RAW_NUM;
            raw.sign = sign_b_eff;
            raw.exp  = exp_wide_t'({2'b00, b.exp});
            raw.frac = b.sig[22:0];
        end else if (b.is_zero) begin
            raw.kind = RAW_NUM;
            raw.sign = a.sign;
            raw.exp  = exp_wide_t'({2'b00, a.exp});
            raw.frac = a.sig[22:0];
        end else if (sum == '0) begin
            // Exact cancellation keeps the sign of a
            raw.kind = RAW_ZERO;
            raw.sign = res_sign;
        end else if (sum[27]) begin
            raw.kind = RAW_NUM;
            raw.sign = res_sign;
            raw.exp  = exp_wide_t'({2'b00, big_exp}) + exp_wide_t'(1);
            raw.frac = sum[26:4];
        end else begin
            raw.kind = RAW_NUM;
            raw.sign = res_sign;
            raw.exp  = exp_wide_t'({2'b00, big_exp}) - exp_wide_t'({5'b00000, lzc});
            raw.frac = norm[25:3];
        end
    end

endmodule

/* rtl/fp_mul.sv */
/*
 * Floating-point multiply on unpacked operands
 * Bias is removed only when both operands are normal
 * Product is truncated, normalization shifts by at most one bit
 */
module fp_mul (
    input  fp_alu_pkg::fp_operand_t a,
    input  fp_alu_pkg::fp_operand_t b,
    input  fp_alu_pkg::fp_fmt_e     fmt,
    output fp_alu_pkg::fp_raw_t     raw
);
    import fp_alu_pkg::*;

    logic        res_sign;
    logic [47:0] prod;
    exp_t        bias;
    exp_wide_t   exp_sum;

    assign res_sign = a.sign ^ b.sign;
    assign prod     = a.sig * b.sig;
    assign bias     = (fmt == FMT_SINGLE) ? SINGLE_BIAS : HALF_BIAS;

    always_comb begin
        exp_sum = exp_wide_t'({2'b00, a.exp}) + exp_wide_t'({2'b00, b.exp});
        if (!a.is_denorm && !b.is_denorm) begin
            exp_sum = exp_sum - exp_wide_t'({2'b00, bias});
        end
    end

    always_comb begin
        raw      = '0;
        raw.sign = res_sign;
        if (a.is_nan || b.is_nan || (a.is_zero && b.is_inf) || (a.is_inf && b.is_zero)) begin
            raw.kind = RAW_NAN;
        end else if (a.is_inf || b.is_inf) begin
            raw.kind = RAW_INF;
        end else if (a.is_zero || b.is_zero) begin
            raw.kind = RAW_ZERO;
        end else if (prod[47]) begin
            // Product in [2, 4)
            raw.kind = RAW_NUM;
            raw.exp  = exp_sum + exp_wide_t'(1);
            raw.frac = prod[46:24];
        end else begin
            raw.kind = RAW_NUM;
            raw.exp  = exp_sum;
            raw.frac = prod[45:23];
        end
    end

endmodule

/* rtl/fp_pack.sv */
/*
 * Encodes a raw result into the selected format
 * Out-of-range exponents saturate to infinity or zero with a flag
 * Half results are zero-extended to 32 bits
 */
module fp_pack (
    input  fp_alu_pkg::fp_raw_t    raw,
    input  fp_alu_pkg::fp_fmt_e    fmt,
    output fp_alu_pkg::fp_word_t   word,
    output fp_alu_pkg::alu_flags_t flags
);
    import fp_alu_pkg::*;

    exp_t      exp_max;
    exp_wide_t res_exp;

    function automatic fp_word_t encode(logic sign, exp_t e, frac_t f, fp_fmt_e form);
        if (form == FMT_SINGLE) begin
            return {sign, e, f};
        end
        return {16'h0000, sign, e[4:0], f[22:HALF_FRAC_PAD]};
    endfunction

    assign exp_max = (fmt == FMT_SINGLE) ? SINGLE_EXP_MAX : HALF_EXP_MAX;
    assign res_exp = raw.exp;

    always_comb begin
        flags = '0;
        case (raw.kind)
            RAW_NAN: begin
                word          = (fmt == FMT_SINGLE) ? QNAN_SINGLE : QNAN_HALF;
                flags.invalid = 1'b1;
            end
            RAW_INF:  word = encode(raw.sign, exp_max, '0, fmt);
            RAW_ZERO: word = encode(raw.sign, '0, '0, fmt);
            default: begin
                if (res_exp >= exp_wide_t'({2'b00, exp_max})) begin
                    word           = encode(raw.sign, exp_max, '0, fmt);
                    flags.overflow = 1'b1;
                end else if (res_exp <= exp_wide_t'(0)) begin
                    word            = encode(raw.sign, '0, '0, fmt);
                    flags.underflow = 1'b1;
                end else begin
                    word = encode(raw.sign, res_exp[7:0], raw.frac, fmt);
                end
            end
        endcase
    end

endmodule

/* rtl/fp_alu_ctrl.sv */
/*
 * Start/valid control of the ALU
 * One operation in flight, start is ignored outside idle
 * Result and flags hold until the next operation completes
 */
module fp_alu_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  fp_alu_pkg::alu_op_e    op,
    input  fp_alu_pkg::fp_raw_t    raw_sum,
    input  fp_alu_pkg::fp_raw_t    raw_prod,
    output fp_alu_pkg::fp_raw_t    raw_sel,
    input  fp_alu_pkg::fp_word_t   pack_word,
    input  fp_alu_pkg::alu_flags_t pack_flags,
    output fp_alu_pkg::fp_word_t   result,
    output fp_alu_pkg::alu_flags_t flags,
    output logic                   valid_out
);
    import fp_alu_pkg::*;

    alu_state_e state;
    alu_state_e next_state;

    // Reserved opcode falls through to the product
    assign raw_sel = (op == OP_ADD || op == OP_SUB) ? raw_sum : raw_prod;

    // ========================================
    // FSM
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            ST_IDLE:    next_state = start ? ST_COMPUTE : ST_IDLE;
            ST_COMPUTE: next_state = ST_IDLE;
            default:    next_state = ST_IDLE;
        endcase
    end

    // Outputs load as the FSM leaves compute
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result    <= '0;
            flags     <= '0;
            valid_out <= 1'b0;
        end else if (state == ST_COMPUTE) begin
            result    <= pack_word;
            flags     <= pack_flags;
            valid_out <= 1'b1;
        end else begin
            valid_out <= 1'b0;
        end
    end

endmodule

/* rtl/fp_alu.sv */
/*
 * Floating-point ALU, single or half precision
 * Operands must stay stable from start until valid_out
 */
module fp_alu (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  fp_alu_pkg::fp_word_t   op_a,
    input  fp_alu_pkg::fp_word_t   op_b,
    input  fp_alu_pkg::alu_op_e    op,
    input  fp_alu_pkg::fp_fmt_e    fmt,
    output fp_alu_pkg::fp_word_t   result,
    output logic                   valid_out,
    output fp_alu_pkg::alu_flags_t flags
);
    import fp_alu_pkg::*;

    fp_operand_t opnd_a;
    fp_operand_t opnd_b;
    fp_raw_t     raw_sum;
    fp_raw_t     raw_prod;
    fp_raw_t     raw_sel;
    fp_word_t    pack_word;
    alu_flags_t  pack_flags;

    fp_unpack u_unpack_a (.word(op_a), .fmt(fmt), .opnd(opnd_a));
    fp_unpack u_unpack_b (.word(op_b), .fmt(fmt), .opnd(opnd_b));

    // Low opcode bit picks subtract
    fp_add_sub u_add_sub (.a(opnd_a), .b(opnd_b), .subtract(op[0]), .raw(raw_sum));

    fp_mul u_mul (.a(opnd_a), .b(opnd_b), .fmt(fmt), .raw(raw_prod));

    fp_pack u_pack (.raw(raw_sel), .fmt(fmt), .word(pack_word), .flags(pack_flags));

    fp_alu_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .raw_sum    (raw_sum),
        .raw_prod   (raw_prod),
        .raw_sel    (raw_sel),
        .pack_word  (pack_word),
        .pack_flags (pack_flags),
        .result     (result),
        .flags      (flags),
        .valid_out  (valid_out)
    );

endmodule

/* bench/fp_alu_asserts.sv */
/*
 * Timing and encoding checks of the ALU, bound into fp_alu
 * A local copy of the IDLE/COMPUTE toggle predicts valid_out
 * Encoding checks look at result only while valid_out is high
 */
module fp_alu_asserts (
    input logic                   clk,
    input logic                   rst,
    input logic                   start,
    input fp_alu_pkg::fp_fmt_e    fmt,
    input fp_alu_pkg::fp_word_t   result,
    input fp_alu_pkg::alu_flags_t flags,
    input logic                   valid_out
);
    timeunit 1ns;
    timeprecision 1ps;
    import fp_alu_pkg::*;

    logic busy;

    // Set for the one cycle after an accepted start
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
        end else begin
            busy <= !busy && start;
        end
    end

    // ========================================
    // Timing
    // ========================================
    a_reset_clear: assert property (@(posedge clk)
        rst && $past(rst) |-> !valid_out && result == '0 && flags == '0)
        else $error("Outputs not cleared during reset");

    // Two edges after a start taken in idle, never otherwise
    a_valid_timing: assert property (@(posedge clk) disable iff (rst)
        valid_out == ($past(start, 2) && !$past(busy, 2)))
        else $error("valid_out does not follow an accepted start by two edges");

    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        valid_out |=> !valid_out)
        else $error("valid_out held longer than one cycle");

    // ========================================
    // Encoding
    // ========================================
    a_half_upper: assert property (@(posedge clk) disable iff (rst)
        valid_out && fmt == FMT_HALF |-> result[31:16] == 16'h0000)
        else $error("Half result has upper bits set");

    a_one_flag: assert property (@(posedge clk) disable iff (rst)
        valid_out |-> $onehot0(flags))
        else $error("More than one flag raised");

    a_invalid_nan: assert property (@(posedge clk) disable iff (rst)
        valid_out && flags.invalid |->
            result == ((fmt == FMT_SINGLE) ? 32'h7FC0_0000 : 32'h0000_7E00))
        else $error("Invalid flag without the quiet NaN");

    a_overflow_inf: assert property (@(posedge clk) disable iff (rst)
        valid_out && flags.overflow |->
            ((fmt == FMT_SINGLE) ? result[30:0] == 31'h7F80_0000 : result[14:0] == 15'h7C00))
        else $error("Overflow flag without an infinity");

    a_underflow_zero: assert property (@(posedge clk) disable iff (rst)
        valid_out && flags.underflow |->
            ((fmt == FMT_SINGLE) ? result[30:0] == '0 : result[14:0] == '0))
        else $error("Underflow flag without a zero");

endmodule

bind fp_alu fp_alu_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .fmt       (fmt),
    .result    (result),
    .flags     (flags),
    .valid_out (valid_out)
);

/* bench/fp_alu_tb.sv */
/*
 * Testbench of the floating-point ALU
 * Integer operands keep every random result exact
 * Operands stay on the inputs until valid_out is seen
 */
module fp_alu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import fp_alu_pkg::*;

    localparam int          CLK_PERIOD      = 4;
    localparam int          RESET_CYCLES    = 10;
    localparam int          NUM_RANDOM      = 200;
    localparam int          NUM_DIRECTED    = 31;
    localparam int          VALID_TIMEOUT   = 8;
    localparam int          WATCHDOG_CYCLES = (NUM_RANDOM + NUM_DIRECTED) * 10 + RESET_CYCLES;
    localparam logic [31:0] LFSR_SEED       = 32'h894cba10;

    localparam alu_flags_t NO_FLAGS       = 3'b000;
    localparam alu_flags_t INVALID_FLAG   = 3'b100;
    localparam alu_flags_t OVERFLOW_FLAG  = 3'b010;
    localparam alu_flags_t UNDERFLOW_FLAG = 3'b001;

    logic        clk;
    logic        rst;
    logic        start;
    fp_word_t    op_a;
    fp_word_t    op_b;
    alu_op_e     op;
    fp_fmt_e     fmt;
    fp_word_t    result;
    logic        valid_out;
    alu_flags_t  flags;
    logic [31:0] lfsr;

    fp_alu DUT (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .op_a      (op_a),
        .op_b      (op_b),
        .op        (op),
        .fmt       (fmt),
        .result    (result),
        .valid_out (valid_out),
        .flags     (flags)
    );

    // ========================================
    // Random bits and encodings
    // ========================================
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    function automatic fp_word_t int_to_fp(input logic sign, input logic [31:0] mag,
                                           input fp_fmt_e form);
        int          msb;
        logic [31:0] shifted;
        if (mag == '0) begin
            return (form == FMT_SINGLE) ? {sign, 31'd0} : {16'h0000, sign, 15'd0};
        end
        msb = 0;
        for (int i = 0; i < 32; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        // Leading one drops out as the hidden bit
        if (form == FMT_SINGLE) begin
            shifted = mag << (23 - msb);
            return {sign, 8'(msb + 127), shifted[22:0]};
        end
        shifted = mag << (10 - msb);
        return {16'h0000, sign, 5'(msb + 15), shifted[9:0]};
    endfunction

    function automatic fp_word_t pow2_word(input logic sign, input int e, input fp_fmt_e form);
        return (form == FMT_SINGLE) ? {sign, 8'(e + 127), 23'd0}
                                    : {16'h0000, sign, 5'(e + 15), 10'd0};
    endfunction

    function automatic fp_word_t inf_word(input logic sign, input fp_fmt_e form);
        return (form == FMT_SINGLE) ? {sign, 8'hFF, 23'd0} : {16'h0000, sign, 5'h1F, 10'd0};
    endfunction

    function automatic fp_word_t qnan_word(input fp_fmt_e form);
        return (form == FMT_SINGLE) ? 32'h7FC0_0000 : 32'h0000_7E00;
    endfunction

    // Exact integer result with a zero signed like a
    function automatic fp_word_t int_model(input alu_op_e code, input logic sign_a,
                                           input logic [31:0] mag_a, input logic sign_b,
                                           input logic [31:0] mag_b, input fp_fmt_e form);
        int val_a;
        int val_b;
        int res;
        val_a = sign_a ? -int'(mag_a) : int'(mag_a);
        val_b = sign_b ? -int'(mag_b) : int'(mag_b);
        case (code)
            OP_ADD:  res = val_a + val_b;
            OP_SUB:  res = val_a - val_b;
            default: res = val_a * val_b;
        endcase
        if (res == 0) begin
            return int_to_fp(sign_a, 32'd0, form);
        end
        return int_to_fp(res < 0, (res < 0) ? -res : res, form);
    endfunction

    // ========================================
    // Checks and operations
    // ========================================
    task automatic fail_value(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("Finished with errors");
        $fatal(1, "Wrong value from the DUT");
    endtask

    task automatic check_result(input fp_word_t exp_word, input alu_flags_t exp_flags,
                                input string what);
        assert (result === exp_word && flags === exp_flags) else begin
            fail_value($sformatf("%s gave %h flags %b, expected %h flags %b",
                                 what, result, flags, exp_word, exp_flags));
        end
    endtask

    task automatic run_op(input fp_word_t a, input fp_word_t b, input alu_op_e code,
                          input fp_fmt_e form, input fp_word_t exp_word,
                          input alu_flags_t exp_flags, input string what);
        int waited;
        @(posedge clk);
        op_a  <= a;
        op_b  <= b;
        op    <= code;
        fmt   <= form;
        start <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!valid_out && waited < VALID_TIMEOUT);
        if (!valid_out) begin
            $display("Finished with errors");
            $fatal(1, "valid_out never came for %s", what);
        end
        check_result(exp_word, exp_flags, what);
    endtask

    // Start stays high into the compute cycle
    task automatic start_during_compute();
        int pulses;
        @(posedge clk);
        op_a  <= int_to_fp(1'b0, 32'd1, FMT_SINGLE);
        op_b  <= int_to_fp(1'b0, 32'd1, FMT_SINGLE);
        op    <= OP_ADD;
        fmt   <= FMT_SINGLE;
        start <= 1'b1;
        repeat (2) @(posedge clk);
        start  <= 1'b0;
        pulses = 0;
        repeat (8) begin
            @(posedge clk);
            if (valid_out) begin
                pulses++;
            end
        end
        assert (pulses == 1) else begin
            fail_value($sformatf("%0d valid pulses for one accepted start", pulses));
        end
        check_result(int_to_fp(1'b0, 32'd2, FMT_SINGLE), NO_FLAGS, "start held in compute");
    endtask

    task automatic special_value_ops(input fp_fmt_e form);
        fp_word_t nan_q;
        fp_word_t nan_s;
        fp_word_t pos_inf;
        fp_word_t neg_inf;
        int       big;
        nan_q   = qnan_word(form);
        nan_s   = inf_word(1'b0, form) | 32'd1;
        pos_inf = inf_word(1'b0, form);
        neg_inf = inf_word(1'b1, form);
        big     = (form == FMT_SINGLE) ? 100 : 10;
        run_op(nan_q, int_to_fp(1'b0, 32'd5, form), OP_ADD, form, nan_q, INVALID_FLAG,
               "NaN plus number");
        run_op(int_to_fp(1'b0, 32'd3, form), nan_s, OP_MUL, form, nan_q, INVALID_FLAG,
               "number times NaN");
        run_op(pos_inf, pos_inf, OP_SUB, form, nan_q, INVALID_FLAG, "inf minus inf");
        run_op(neg_inf, pos_inf, OP_ADD, form, nan_q, INVALID_FLAG, "-inf plus inf");
        run_op(int_to_fp(1'b0, 32'd0, form), neg_inf, OP_MUL, form, nan_q, INVALID_FLAG,
               "zero times inf");
        run_op(pos_inf, int_to_fp(1'b1, 32'd0, form), OP_RSVD, form, nan_q, INVALID_FLAG,
               "inf times zero on code 3");
        run_op(neg_inf, int_to_fp(1'b0, 32'd7, form), OP_ADD, form, neg_inf, NO_FLAGS,
               "-inf plus number");
        run_op(int_to_fp(1'b0, 32'd3, form), pos_inf, OP_SUB, form, neg_inf, NO_FLAGS,
               "number minus inf");
        // Zero products signed by the XOR of the signs
        run_op(int_to_fp(1'b1, 32'd0, form), int_to_fp(1'b0, 32'd9, form), OP_MUL, form,
               int_to_fp(1'b1, 32'd0, form), NO_FLAGS, "-0 times 9");
        run_op(int_to_fp(1'b0, 32'd0, form), int_to_fp(1'b1, 32'd5, form), OP_RSVD, form,
               int_to_fp(1'b1, 32'd0, form), NO_FLAGS, "+0 times -5");
        run_op(int_to_fp(1'b1, 32'd3, form), int_to_fp(1'b1, 32'd0, form), OP_MUL, form,
               int_to_fp(1'b0, 32'd0, form), NO_FLAGS, "-3 times -0");
        run_op(pow2_word(1'b0, big, form), pow2_word(1'b1, big, form), OP_MUL, form,
               neg_inf, OVERFLOW_FLAG, "large product");
        run_op(pow2_word(1'b1, -big, form), pow2_word(1'b0, -big, form), OP_MUL, form,
               int_to_fp(1'b1, 32'd0, form), UNDERFLOW_FLAG, "small product");
    endtask

    // Exact cancellation keeps the sign of a
    task automatic cancel_ops(input fp_fmt_e form);
        run_op(int_to_fp(1'b1, 32'd5, form), int_to_fp(1'b0, 32'd5, form), OP_ADD, form,
               int_to_fp(1'b1, 32'd0, form), NO_FLAGS, "-5 plus 5");
        run_op(int_to_fp(1'b0, 32'd6, form), int_to_fp(1'b0, 32'd6, form), OP_SUB, form,
               int_to_fp(1'b0, 32'd0, form), NO_FLAGS, "6 minus 6");
    endtask

    task automatic random_int_ops(input int count);
        logic [31:0] bits;
        logic [31:0] mag_a;
        logic [31:0] mag_b;
        logic        sign_a;
        logic        sign_b;
        alu_op_e     code;
        fp_fmt_e     form;
        int          width;
        for (int n = 0; n < count; n++) begin
            bits   = take_bits(1);
            form   = bits[0] ? FMT_SINGLE : FMT_HALF;
            width  = (form == FMT_SINGLE) ? 8 : 5;
            bits   = take_bits(2);
            code   = alu_op_e'(bits[1:0]);
            mag_a  = take_bits(width);
            mag_b  = take_bits(width);
            bits   = take_bits(2);
            sign_a = bits[1];
            sign_b = bits[0];
            if (mag_a == '0) begin
                mag_a = 32'd1;
            end
            if (mag_b == '0) begin
                mag_b = 32'd1;
            end
            run_op(int_to_fp(sign_a, mag_a, form), int_to_fp(sign_b, mag_b, form), code, form,
                   int_model(code, sign_a, mag_a, sign_b, mag_b, form), NO_FLAGS,
                   $sformatf("op %0d fmt %0d on %0d and %0d", code, form, mag_a, mag_b));
        end
    endtask

    // ========================================
    // Clock, watchdog and test sequence
    // ========================================
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Finished with errors");
        $fatal(1, "Watchdog expired before the tests completed");
    end

    initial begin
        rst   = 1'b1;
        start = 1'b0;
        op_a  = '0;
        op_b  = '0;
        op    = OP_ADD;
        fmt   = FMT_SINGLE;
        lfsr  = LFSR_SEED;
        repeat (RESET_CYCLES) @(posedge clk);
        assert (!valid_out && result == '0 && flags == '0) else begin
            fail_value("outputs not cleared by reset");
        end
        rst <= 1'b0;
        start_during_compute();
        special_value_ops(FMT_SINGLE);
        special_value_ops(FMT_HALF);
        cancel_ops(FMT_SINGLE);
        cancel_ops(FMT_HALF);
        random_int_ops(NUM_RANDOM);
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* fp_alu.f */
rtl/fp_alu_pkg.sv
rtl/fp_unpack.sv
rtl/fp_add_sub.sv
rtl/fp_mul.sv
rtl/fp_pack.sv
rtl/fp_alu_ctrl.sv
rtl/fp_alu.sv
bench/fp_alu_asserts.sv
bench/fp_alu_tb.sv

/* Makefile */
# Verilator build and run of the floating-point ALU testbench

VERILATOR ?= verilator
TOP       ?= fp_alu_tb
FILELIST  ?= fp_alu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
